// ==== Makefile ====
TOP = tb_top

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== compile.f ====
hdl/core_pkg.sv
hdl/mem_bus_if.sv
hdl/instr_if.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/load_store_unit.sv
hdl/bus_arbiter.sv
hdl/mini_core.sv
verif/core_assert.sv
verif/tb_top.sv

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import core_pkg::*; (
    input logic clk,
    input logic reset,
    mem_bus_if.slave inst_bus,
    mem_bus_if.slave data_bus,
    output logic bus_valid,
    output logic bus_write,
    output word_t bus_addr,
    output word_t bus_wdata,
    input logic bus_addr_ok,
    input logic bus_data_ok,
    input word_t bus_rdata
);

    // one transaction open, and who owns it
    logic busy;
    logic owner_is_data;
    logic grant_data;
    logic accepted;

    // data side wins ties
    assign grant_data = data_bus.valid;

    assign bus_valid = !busy && (data_bus.valid || inst_bus.valid);
    assign bus_write = grant_data ? data_bus.write : inst_bus.write;
    assign bus_addr = grant_data ? data_bus.addr : inst_bus.addr;
    assign bus_wdata = grant_data ? data_bus.wdata : inst_bus.wdata;

    assign accepted = bus_valid && bus_addr_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            owner_is_data <= 1'b0;
        end else if (accepted) begin
            busy <= 1'b1;
            owner_is_data <= grant_data;
        end else if (bus_data_ok) begin
            busy <= 1'b0;
        end
    end

    // addr_ok only to the granted master
    assign data_bus.addr_ok = !busy && grant_data && bus_addr_ok;
    assign inst_bus.addr_ok = !busy && !grant_data && bus_addr_ok;

    // response steered to the owner
    assign data_bus.data_ok = busy && owner_is_data && bus_data_ok;
    assign inst_bus.data_ok = busy && !owner_is_data && bus_data_ok;
    assign data_bus.rdata = bus_rdata;
    assign inst_bus.rdata = bus_rdata;

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    // reset vector used unless the top level overrides it
    localparam logic [31:0] DEFAULT_RESET_PC = 32'h0000_0100;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function codes under OP_SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

endpackage

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit import core_pkg::*; (
    input logic clk,
    input logic reset,
    instr_if.exec ifc,
    lsu_if.exec lsu
);

    word_t regs [32];

    opcode_t opcode;
    funct_t funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t imm_sext;
    word_t imm_zext;
    word_t rs_val;
    word_t rt_val;

    word_t alu_result;
    reg_addr_t dest;
    logic wr_en;
    logic is_mem;
    logic is_load;
    logic br_taken;
    logic take;
    logic write_seen;

    // field split
    assign opcode = opcode_t'(ifc.instr[31:26]);
    assign funct = funct_t'(ifc.instr[5:0]);
    assign rs = ifc.instr[25:21];
    assign rt = ifc.instr[20:16];
    assign rd = ifc.instr[15:11];
    assign imm_sext = {{16{ifc.instr[15]}}, ifc.instr[15:0]};
    assign imm_zext = {16'h0000, ifc.instr[15:0]};

    // register 0 reads as zero
    assign rs_val = (rs == 5'd0) ? '0 : regs[rs];
    assign rt_val = (rt == 5'd0) ? '0 : regs[rt];

    always_comb begin
        alu_result = '0;
        dest = rt;
        wr_en = 1'b0;
        is_mem = 1'b0;
        is_load = 1'b0;
        br_taken = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest = rd;
                wr_en = 1'b1;
                case (funct)
                    FN_ADDU: alu_result = rs_val + rt_val;
                    FN_SUBU: alu_result = rs_val - rt_val;
                    FN_AND:  alu_result = rs_val & rt_val;
                    FN_OR:   alu_result = rs_val | rt_val;
                    FN_SLT:  alu_result = {31'd0, $signed(rs_val) < $signed(rt_val)};
                    // unknown function does not write
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_result = rs_val + imm_sext;
                wr_en = 1'b1;
            end
            OP_ORI: begin
                alu_result = rs_val | imm_zext;
                wr_en = 1'b1;
            end
            OP_LUI: begin
                alu_result = {ifc.instr[15:0], 16'h0000};
                wr_en = 1'b1;
            end
            OP_BEQ: begin
                br_taken = (rs_val == rt_val);
            end
            OP_BNE: begin
                br_taken = (rs_val != rt_val);
            end
            OP_LW: begin
                is_mem = 1'b1;
                is_load = 1'b1;
                wr_en = 1'b1;
            end
            OP_SW: begin
                is_mem = 1'b1;
            end
            default: begin
                // treated as a nop
                wr_en = 1'b0;
            end
        endcase
    end

    // memory ops wait for the LSU while everything else retires at once
    assign take = ifc.instr_valid && (!is_mem || lsu.done);
    assign write_seen = take && wr_en && (dest != 5'd0);

    always_ff @(posedge clk) begin
        if (write_seen) begin
            regs[dest] <= is_load ? lsu.rdata : alu_result;
        end
    end

    assign ifc.take = take;
    assign ifc.redirect = take && br_taken;
    // branch target from pc+4 without a delay slot
    assign ifc.target = ifc.pc + 32'd4 + {imm_sext[29:0], 2'b00};

    // request held until done
    assign lsu.req = ifc.instr_valid && is_mem;
    assign lsu.write = (opcode == OP_SW);
    assign lsu.addr = rs_val + imm_sext;
    assign lsu.wdata = rt_val;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input logic clk,
    input logic reset,
    mem_bus_if.master bus,
    instr_if.fetch ifc
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT,
        F_HOLD
    } fetch_state_t;

    fetch_state_t state;
    word_t pc;
    word_t instr_buf;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= F_IDLE;
            pc <= RESET_PC;
        end else begin
            case (state)
                F_IDLE: begin
                    state <= F_REQ;
                end
                F_REQ: begin
                    if (bus.addr_ok) begin
                        state <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (bus.data_ok) begin
                        state <= F_HOLD;
                    end
                end
                F_HOLD: begin
                    // next fetch only once this one is consumed
                    if (ifc.take) begin
                        state <= F_REQ;
                        pc <= ifc.redirect ? ifc.target : pc + 32'd4;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // one-instruction buffer
    always_ff @(posedge clk) begin
        if (state == F_WAIT && bus.data_ok) begin
            instr_buf <= bus.rdata;
        end
    end

    // read-only master, always the current pc
    assign bus.valid = (state == F_REQ);
    assign bus.write = 1'b0;
    assign bus.addr = pc;
    assign bus.wdata = '0;

    assign ifc.instr_valid = (state == F_HOLD);
    assign ifc.instr = instr_buf;
    assign ifc.pc = pc;

endmodule

`default_nettype wire

// ==== hdl/instr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// instruction hand-over, fetch holds instr_valid until execute takes it
interface instr_if import core_pkg::*; ();
    logic  instr_valid;
    word_t instr;
    word_t pc;
    logic  take;
    // redirect only ever pulses together with take
    logic  redirect;
    word_t target;

    modport fetch (
        output instr_valid, instr, pc,
        input  take, redirect, target
    );

    modport exec (
        input  instr_valid, instr, pc,
        output take, redirect, target
    );
endinterface

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import core_pkg::*; (
    input logic clk,
    input logic reset,
    lsu_if.lsu lsu,
    mem_bus_if.master bus
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_BUS,
        L_WAIT,
        L_DONE
    } lsu_state_t;

    lsu_state_t state;
    logic write_q;
    word_t addr_q;
    word_t wdata_q;
    word_t rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= L_IDLE;
        end else begin
            case (state)
                L_IDLE:  if (lsu.req) state <= L_BUS;
                L_BUS:   if (bus.addr_ok) state <= L_WAIT;
                L_WAIT:  if (bus.data_ok) state <= L_DONE;
                // req is still high here, so no new capture this cycle
                L_DONE:  state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

    // request and load data payload
    always_ff @(posedge clk) begin
        if (state == L_IDLE && lsu.req) begin
            write_q <= lsu.write;
            addr_q <= lsu.addr;
            wdata_q <= lsu.wdata;
        end
        if (state == L_WAIT && bus.data_ok) begin
            rdata_q <= bus.rdata;
        end
    end

    assign bus.valid = (state == L_BUS);
    assign bus.write = write_q;
    assign bus.addr = addr_q;
    assign bus.wdata = wdata_q;

    assign lsu.done = (state == L_DONE);
    assign lsu.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one master to one slave, valid/addr_ok request and data_ok response
interface mem_bus_if import core_pkg::*; ();
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;

    modport master (
        output valid, write, addr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  valid, write, addr, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

// word load/store request from execute to the LSU
interface lsu_if import core_pkg::*; ();
    logic  req;
    logic  write;
    word_t addr;
    word_t wdata;
    logic  done;
    word_t rdata;

    modport exec (
        output req, write, addr, wdata,
        input  done, rdata
    );

    modport lsu (
        input  req, write, addr, wdata,
        output done, rdata
    );
endinterface

`default_nettype wire

// ==== hdl/mini_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_core import core_pkg::*; #(
    parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
    input logic clk,
    input logic reset,
    output logic bus_valid,
    output logic bus_write,
    output word_t bus_addr,
    output word_t bus_wdata,
    input logic bus_addr_ok,
    input logic bus_data_ok,
    input word_t bus_rdata
);

    mem_bus_if inst_bus ();
    mem_bus_if data_bus ();
    instr_if ifc ();
    lsu_if lsu_link ();

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk),
        .reset(reset),
        .bus(inst_bus.master),
        .ifc(ifc.fetch)
    );

    exec_unit u_exec (
        .clk(clk),
        .reset(reset),
        .ifc(ifc.exec),
        .lsu(lsu_link.exec)
    );

    load_store_unit u_lsu (
        .clk(clk),
        .reset(reset),
        .lsu(lsu_link.lsu),
        .bus(data_bus.master)
    );

    // single external bus shared by fetch and load/store
    bus_arbiter u_arb (
        .clk(clk),
        .reset(reset),
        .inst_bus(inst_bus.slave),
        .data_bus(data_bus.slave),
        .bus_valid(bus_valid),
        .bus_write(bus_write),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_addr_ok(bus_addr_ok),
        .bus_data_ok(bus_data_ok),
        .bus_rdata(bus_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the shared bus as seen by bus_arbiter
module core_assert import core_pkg::*; (
    input logic clk,
    input logic reset,
    input logic bus_valid,
    input logic bus_write,
    input word_t bus_addr,
    input word_t bus_wdata,
    input logic bus_addr_ok,
    input logic bus_data_ok,
    input logic busy
);

    int failures = 0;
    logic open_q;

    // open transaction tracked from the bus pins alone
    always_ff @(posedge clk) begin
        if (reset) begin
            open_q <= 1'b0;
        end else if (bus_valid && bus_addr_ok) begin
            open_q <= 1'b1;
        end else if (bus_data_ok) begin
            open_q <= 1'b0;
        end
    end

    // request held steady until addr_ok
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        bus_valid && !bus_addr_ok |=> bus_valid && $stable(bus_write)
            && $stable(bus_addr) && $stable(bus_wdata))
    else begin
        $error("bus request changed before it was accepted");
        failures = failures + 1;
    end

    // a response needs a recorded owner
    a_resp_owned: assert property (@(posedge clk) disable iff (reset)
        bus_data_ok |-> busy)
    else begin
        $error("data_ok seen with no open transaction");
        failures = failures + 1;
    end

    // one open transaction at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        open_q |-> !bus_valid)
    else begin
        $error("new request granted while a transaction is open");
        failures = failures + 1;
    end

endmodule

bind bus_arbiter core_assert u_core_assert (
    .clk(clk),
    .reset(reset),
    .bus_valid(bus_valid),
    .bus_write(bus_write),
    .bus_addr(bus_addr),
    .bus_wdata(bus_wdata),
    .bus_addr_ok(bus_addr_ok),
    .bus_data_ok(bus_data_ok),
    .busy(busy)
);

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import core_pkg::*; ();

    localparam word_t RESET_PC = 32'h0000_0100;
    localparam word_t DATA_BASE = 32'h0000_0200;
    localparam int MEM_WORDS = 256;
    localparam int CODE_IDX = 64;
    localparam int PROG_LEN = 38;
    localparam word_t HALT_ADDR = RESET_PC + 32'd4 * (PROG_LEN - 1);
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_NS = PROG_LEN * 20 * 4 + RESET_CYCLES * 4;
    localparam int MAX_STEPS = 1000;

    typedef enum {SL_IDLE, SL_ADDR, SL_ACC, SL_RESP} slave_state_t;

    logic clk;
    logic reset;
    logic bus_valid;
    logic bus_write;
    word_t bus_addr;
    word_t bus_wdata;
    logic bus_addr_ok;
    logic bus_data_ok;
    word_t bus_rdata;

    word_t mem [MEM_WORDS];
    int emit_ptr = 0;

    // reference streams and observed streams
    word_t exp_fetch [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];
    word_t act_fetch [$];
    word_t act_st_addr [$];
    word_t act_st_data [$];

    int fetch_errors = 0;
    int store_errors = 0;
    logic timed_out = 1'b0;

    slave_state_t slave_state = SL_IDLE;
    int addr_wait;
    int resp_wait;
    logic req_write;
    word_t req_addr;
    word_t req_wdata;
    word_t resp_data;

    mini_core #(
        .RESET_PC(RESET_PC)
    ) dut (
        .clk(clk),
        .reset(reset),
        .bus_valid(bus_valid),
        .bus_write(bus_write),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_addr_ok(bus_addr_ok),
        .bus_data_ok(bus_data_ok),
        .bus_rdata(bus_rdata)
    );

    function automatic word_t r_type(input funct_t fn, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input word_t instr);
        mem[CODE_IDX + emit_ptr] = instr;
        emit_ptr++;
    endtask

    // ISA model, runs the loaded program until the halt is fetched twice
    function automatic void run_reference();
        word_t regs [32];
        word_t rmem [MEM_WORDS];
        word_t pc;
        word_t next_pc;
        word_t instr;
        word_t a;
        word_t b;
        word_t imm_s;
        word_t ea;
        int halt_seen;
        int steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        rmem = mem;
        pc = RESET_PC;
        halt_seen = 0;
        steps = 0;
        while (halt_seen < 2 && steps < MAX_STEPS) begin
            exp_fetch.push_back(pc);
            if (pc == HALT_ADDR) begin
                halt_seen++;
            end
            instr = rmem[pc[9:2]];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            imm_s = {{16{instr[15]}}, instr[15:0]};
            ea = a + imm_s;
            next_pc = pc + 32'd4;
            case (instr[31:26])
                OP_SPECIAL: begin
                    case (instr[5:0])
                        FN_ADDU: regs[instr[15:11]] = a + b;
                        FN_SUBU: regs[instr[15:11]] = a - b;
                        FN_AND:  regs[instr[15:11]] = a & b;
                        FN_OR:   regs[instr[15:11]] = a | b;
                        FN_SLT:  regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                OP_ADDIU: regs[instr[20:16]] = a + imm_s;
                OP_ORI:   regs[instr[20:16]] = a | {16'h0000, instr[15:0]};
                OP_LUI:   regs[instr[20:16]] = {instr[15:0], 16'h0000};
                OP_LW:    regs[instr[20:16]] = rmem[ea[9:2]];
                OP_SW: begin
                    rmem[ea[9:2]] = b;
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                end
                OP_BEQ: if (a == b) next_pc = pc + 32'd4 + (imm_s << 2);
                OP_BNE: if (a != b) next_pc = pc + 32'd4 + (imm_s << 2);
                default: ;
            endcase
            regs[0] = '0;
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic compare_word(input string test_name, input word_t expected,
                                input word_t actual, input bit store_side);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
            if (store_side) begin
                store_errors++;
            end else begin
                fetch_errors++;
            end
        end
    endtask

    task automatic finish_run();
        int assert_failures;
        assert_failures = dut.u_arb.u_core_assert.failures;
        $display("fetch errors: %0d, store errors: %0d, assertion failures: %0d",
                 fetch_errors, store_errors, assert_failures);
        if (fetch_errors == 0 && store_errors == 0 && assert_failures == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : stimulus
        void'($urandom(32'h0c14_8730));
        reset = 1'b1;
        bus_addr_ok = 1'b0;
        bus_data_ok = 1'b0;
        bus_rdata = '0;
        // fill pattern from the byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'ha5c3_0000 + word_t'(i) * 4;
        end
        // ALU and immediates, SLT on negative operands
        emit(i_type(OP_LUI, 5'd0, 5'd1, 16'h8000));
        emit(i_type(OP_ORI, 5'd1, 5'd1, 16'h0005));
        emit(i_type(OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
        emit(i_type(OP_ADDIU, 5'd0, 5'd3, 16'h0200));
        emit(r_type(FN_SLT, 5'd1, 5'd2, 5'd4));
        emit(r_type(FN_SLT, 5'd2, 5'd1, 5'd5));
        emit(r_type(FN_ADDU, 5'd1, 5'd2, 5'd6));
        emit(r_type(FN_SUBU, 5'd2, 5'd1, 5'd7));
        emit(r_type(FN_AND, 5'd1, 5'd2, 5'd8));
        emit(r_type(FN_OR, 5'd1, 5'd2, 5'd9));
        emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'h0007));
        emit(i_type(OP_SW, 5'd3, 5'd4, 16'h0000));
        emit(i_type(OP_SW, 5'd3, 5'd5, 16'h0004));
        emit(i_type(OP_SW, 5'd3, 5'd6, 16'h0008));
        emit(i_type(OP_SW, 5'd3, 5'd7, 16'h000c));
        emit(i_type(OP_SW, 5'd3, 5'd8, 16'h0010));
        emit(i_type(OP_SW, 5'd3, 5'd9, 16'h0014));
        emit(i_type(OP_SW, 5'd3, 5'd0, 16'h0018));
        // loads of preloaded words, stored back
        emit(i_type(OP_LW, 5'd3, 5'd10, 16'h0040));
        emit(i_type(OP_LW, 5'd3, 5'd11, 16'h0044));
        emit(i_type(OP_SW, 5'd3, 5'd10, 16'h001c));
        emit(i_type(OP_SW, 5'd3, 5'd11, 16'h0020));
        // counted loop on BNE
        emit(i_type(OP_ADDIU, 5'd0, 5'd12, 16'h0003));
        emit(i_type(OP_ADDIU, 5'd0, 5'd13, 16'h0000));
        emit(r_type(FN_ADDU, 5'd13, 5'd12, 5'd13));
        emit(i_type(OP_ADDIU, 5'd12, 5'd12, 16'hffff));
        emit(i_type(OP_BNE, 5'd12, 5'd0, 16'hfffd));
        emit(i_type(OP_SW, 5'd3, 5'd13, 16'h0024));
        // not taken, then taken forward branches over stores
        emit(i_type(OP_BEQ, 5'd1, 5'd2, 16'h0001));
        emit(i_type(OP_BEQ, 5'd0, 5'd0, 16'h0001));
        emit(i_type(OP_SW, 5'd3, 5'd1, 16'h0028));
        emit(i_type(OP_BNE, 5'd1, 5'd2, 16'h0001));
        emit(i_type(OP_SW, 5'd3, 5'd2, 16'h002c));
        emit(i_type(OP_LW, 5'd3, 5'd14, 16'h0008));
        emit(i_type(OP_SW, 5'd3, 5'd14, 16'h0030));
        emit(i_type(OP_LW, 5'd3, 5'd15, 16'h0048));
        emit(i_type(OP_SW, 5'd3, 5'd15, 16'h0034));
        // halt loop
        emit(i_type(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        run_reference();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_word("reset_valid", 32'd0, {31'd0, bus_valid}, 1'b0);
        end
        reset = 1'b0;
    end

    // bus slave with random addr_ok and data_ok delays
    always @(negedge clk) begin
        bus_data_ok = 1'b0;
        if (slave_state == SL_ACC) begin
            // accepted at the last rising edge
            bus_addr_ok = 1'b0;
            if (req_write) begin
                mem[req_addr[9:2]] = req_wdata;
                act_st_addr.push_back(req_addr);
                act_st_data.push_back(req_wdata);
            end else begin
                resp_data = mem[req_addr[9:2]];
                if (req_addr < DATA_BASE) begin
                    act_fetch.push_back(req_addr);
                end
            end
            resp_wait = $urandom % 4;
            slave_state = SL_RESP;
        end
        if (slave_state == SL_RESP) begin
            if (resp_wait == 0) begin
                bus_data_ok = 1'b1;
                bus_rdata = resp_data;
                slave_state = SL_IDLE;
            end else begin
                resp_wait--;
            end
        end else if (slave_state == SL_IDLE && bus_valid === 1'b1) begin
            addr_wait = $urandom % 4;
            slave_state = SL_ADDR;
        end
        if (slave_state == SL_ADDR) begin
            if (addr_wait == 0) begin
                bus_addr_ok = 1'b1;
                req_write = bus_write;
                req_addr = bus_addr;
                req_wdata = bus_wdata;
                slave_state = SL_ACC;
            end else begin
                addr_wait--;
            end
        end
    end

    initial begin : compare_streams
        int fetch_idx;
        int store_idx;
        int halt_seen;
        word_t addr;
        word_t data;
        fetch_idx = 0;
        store_idx = 0;
        halt_seen = 0;
        while (halt_seen < 2) begin
            @(posedge clk);
            while (act_fetch.size() > 0) begin
                addr = act_fetch.pop_front();
                if (fetch_idx < exp_fetch.size()) begin
                    compare_word($sformatf("fetch %0d", fetch_idx), exp_fetch[fetch_idx],
                                 addr, 1'b0);
                end else begin
                    $display("fetch of %h beyond the end of the reference trace", addr);
                    fetch_errors++;
                end
                fetch_idx++;
                if (addr == HALT_ADDR) begin
                    halt_seen++;
                end
            end
            while (act_st_addr.size() > 0) begin
                addr = act_st_addr.pop_front();
                data = act_st_data.pop_front();
                if (store_idx < exp_st_addr.size()) begin
                    compare_word($sformatf("store %0d addr", store_idx), exp_st_addr[store_idx],
                                 addr, 1'b1);
                    compare_word($sformatf("store %0d data", store_idx), exp_st_data[store_idx],
                                 data, 1'b1);
                end else begin
                    $display("extra store of %h to %h", data, addr);
                    store_errors++;
                end
                store_idx++;
            end
        end
        compare_word("fetch_count", word_t'(exp_fetch.size()), word_t'(fetch_idx), 1'b0);
        compare_word("store_count", word_t'(exp_st_addr.size()), word_t'(store_idx), 1'b1);
        finish_run();
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: halt loop not reached within %0d ns", WATCHDOG_NS);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire
